// File: all.f
source/cpu_pkg.sv
source/adder.sv
source/arith_unit.sv
source/logic_shift_unit.sv
source/alu.sv
source/exec_stage.sv
verification/exec_stage_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module exec_stage_tb -f all.f \
	-o exec_stage_sim || exit 1
out=$(./obj_dir/exec_stage_sim 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Testbench passed" && exit 0 || exit 1

// File: source/adder.sv
module adder import cpu_pkg::*; (
	input  logic [DATA_W-1:0] a,
	input  logic [DATA_W-1:0] b,
	input  logic              sub,   // Subtract a - b
	output logic [DATA_W-1:0] sum,
	output logic              ovfl   // Signed overflow
);

	logic [DATA_W-1:0] b_eff;  // b or its complement
	logic [DATA_W-1:0] g;      // Bit generate
	logic [DATA_W-1:0] p;      // Bit propagate
	logic [DATA_W-1:0] c;      // Carry into each bit

	assign b_eff = sub ? ~b : b;
	assign g     = a & b_eff;
	assign p     = a ^ b_eff;
	assign c[0]  = sub;  // +1 completes two's complement

	// Lookahead inside each nibble, group carries ripple between nibbles
	for (genvar k = 0; k < DATA_W / 4; k++) begin : g_cla
		assign c[4*k+1] = g[4*k] | (p[4*k] & c[4*k]);
		assign c[4*k+2] = g[4*k+1] | (p[4*k+1] & g[4*k]) | (p[4*k+1] & p[4*k] & c[4*k]);
		assign c[4*k+3] = g[4*k+2] | (p[4*k+2] & g[4*k+1])
			| (p[4*k+2] & p[4*k+1] & g[4*k])
			| (p[4*k+2] & p[4*k+1] & p[4*k] & c[4*k]);
		if (k < DATA_W / 4 - 1) begin : g_out  // Top group carry-out is not needed
			assign c[4*k+4] = g[4*k+3] | (p[4*k+3] & g[4*k+2])
				| (p[4*k+3] & p[4*k+2] & g[4*k+1])
				| (p[4*k+3] & p[4*k+2] & p[4*k+1] & g[4*k])
				| (p[4*k+3] & p[4*k+2] & p[4*k+1] & p[4*k] & c[4*k]);
		end
	end

	assign sum = p ^ c;

	// Same operand signs, different result sign
	assign ovfl = (a[DATA_W-1] == b_eff[DATA_W-1]) & (sum[DATA_W-1] != a[DATA_W-1]);

endmodule

// File: source/alu.sv
module alu import cpu_pkg::*; (
	input  logic [DATA_W-1:0] a,
	input  logic [DATA_W-1:0] b,
	input  alu_op_e           op,
	output logic [DATA_W-1:0] result,
	output alu_flags_t        flags,    // Candidate flag values
	output alu_flags_t        flag_we   // Which flags this op writes
);

	arith_out_t arith;
	logic_out_t logic_r;
	logic       is_addsub;
	logic       z_op;       // Ops that report zero

	arith_unit u_arith (
		.a     (a),
		.b     (b),
		.op    (op),
		.arith (arith)
	);

	logic_shift_unit u_logic (
		.a       (a),
		.b       (b),
		.op      (op),
		.logic_r (logic_r)
	);

	// Result mux
	always_comb begin
		case (op)
			OP_ADD, OP_SUB: result = arith.sum;
			OP_XOR:         result = logic_r.xor_r;
			OP_RED:         result = arith.red;
			OP_SLL, OP_SRA: result = logic_r.shift;
			OP_ROR:         result = logic_r.ror;
			OP_PADDSB:      result = arith.paddsb;
			OP_LW, OP_SW:   result = arith.addr;
			OP_LLB:         result = logic_r.llb;
			OP_LHB:         result = logic_r.lhb;
			default:        result = '0;  // Opcodes 12-15
		endcase
	end

	assign is_addsub = (op == OP_ADD) || (op == OP_SUB);

	always_comb begin
		case (op)
			OP_ADD, OP_SUB, OP_XOR, OP_SLL, OP_SRA, OP_ROR: z_op = 1'b1;
			default: z_op = 1'b0;
		endcase
	end

	// Flag values, only meaningful where enabled
	assign flags.n = arith.sum[DATA_W-1];
	assign flags.z = (result == '0);
	assign flags.v = arith.ovfl;

	assign flag_we.n = is_addsub;
	assign flag_we.z = z_op;
	assign flag_we.v = is_addsub;

endmodule

// File: source/arith_unit.sv
module arith_unit import cpu_pkg::*; (
	input  logic [DATA_W-1:0] a,
	input  logic [DATA_W-1:0] b,
	input  alu_op_e           op,
	output arith_out_t        arith
);

	logic signed [8:0] red_hi;   // Upper byte sum
	logic signed [8:0] red_lo;   // Lower byte sum
	logic signed [9:0] red_tot;

	// Saturating add of two signed nibbles
	function automatic logic [3:0] sat_add4(input logic [3:0] x, input logic [3:0] y);
		logic [4:0] s;
		s = {x[3], x} + {y[3], y};
		if (s[4] != s[3])
			return s[4] ? 4'h8 : 4'h7;  // Clamp to -8 or 7
		return s[3:0];
	endfunction

	// ADD/SUB, op bit 0 picks subtract
	adder u_main_add (
		.a    (a),
		.b    (b),
		.sub  (op[0]),
		.sum  (arith.sum),
		.ovfl (arith.ovfl)
	);

	// LW/SW address, base forced halfword aligned
	adder u_addr_add (
		.a    ({a[DATA_W-1:1], 1'b0}),
		.b    (b),
		.sub  (1'b0),
		.sum  (arith.addr),
		.ovfl ()
	);

	// RED
	assign red_hi  = $signed({a[DATA_W-1], a[DATA_W-1:8]}) + $signed({b[DATA_W-1], b[DATA_W-1:8]});
	assign red_lo  = $signed({a[7], a[7:0]}) + $signed({b[7], b[7:0]});
	assign red_tot = red_hi + red_lo;  // Signed, widened
	assign arith.red = {{(DATA_W-10){red_tot[9]}}, red_tot};

	// PADDSB, four independent lanes
	for (genvar k = 0; k < DATA_W / 4; k++) begin : g_lane
		assign arith.paddsb[4*k +: 4] = sat_add4(a[4*k +: 4], b[4*k +: 4]);
	end

endmodule

// File: source/cpu_pkg.sv
package cpu_pkg;

	localparam int DATA_W = 16; // Machine word

	// Opcode field of a decoded instruction
	typedef enum logic [3:0] {
		OP_ADD    = 4'd0,
		OP_SUB    = 4'd1,
		OP_XOR    = 4'd2,
		OP_RED    = 4'd3,  // Byte reduction
		OP_SLL    = 4'd4,
		OP_SRA    = 4'd5,
		OP_ROR    = 4'd6,
		OP_PADDSB = 4'd7,  // Nibble saturating add
		OP_LW     = 4'd8,
		OP_SW     = 4'd9,
		OP_LLB    = 4'd10,
		OP_LHB    = 4'd11
	} alu_op_e;

	// Condition flags, N on top as in the 3-bit flag word
	typedef struct packed {
		logic n;
		logic z;
		logic v;
	} alu_flags_t;

	typedef struct packed {
		alu_op_e           op;
		logic [DATA_W-1:0] a;  // Register value
		logic [DATA_W-1:0] b;  // Register value or extended immediate
	} exec_req_t;

	typedef struct packed {
		logic [DATA_W-1:0] result;
		alu_flags_t        flags;  // Flag register after this instruction
	} exec_rsp_t;

	// Arithmetic side results
	typedef struct packed {
		logic [DATA_W-1:0] sum;
		logic              ovfl;
		logic [DATA_W-1:0] red;
		logic [DATA_W-1:0] paddsb;
		logic [DATA_W-1:0] addr;   // LW/SW effective address
	} arith_out_t;

	// Bitwise and positional results
	typedef struct packed {
		logic [DATA_W-1:0] xor_r;
		logic [DATA_W-1:0] shift;  // SLL or SRA
		logic [DATA_W-1:0] ror;
		logic [DATA_W-1:0] llb;
		logic [DATA_W-1:0] lhb;
	} logic_out_t;

endpackage

// File: source/exec_stage.sv
module exec_stage import cpu_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      in_valid,
	output logic      in_ready,
	input  exec_req_t in_req,
	output logic      out_valid,
	input  logic      out_ready,
	output exec_rsp_t out_rsp
);

	logic [DATA_W-1:0] alu_result;
	alu_flags_t        alu_flags;
	alu_flags_t        flag_we;
	alu_flags_t        flag_q;    // Condition flag register
	alu_flags_t        flag_d;    // Flags after merging this op
	logic              accept;

	alu u_alu (
		.a       (in_req.a),
		.b       (in_req.b),
		.op      (in_req.op),
		.result  (alu_result),
		.flags   (alu_flags),
		.flag_we (flag_we)
	);

	// Accept when the output slot is free or draining this cycle
	assign in_ready = ~out_valid | out_ready;
	assign accept   = in_valid & in_ready;

	// Per-flag merge
	assign flag_d.n = flag_we.n ? alu_flags.n : flag_q.n;
	assign flag_d.z = flag_we.z ? alu_flags.z : flag_q.z;
	assign flag_d.v = flag_we.v ? alu_flags.v : flag_q.v;

	// Control state
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			flag_q    <= '0;
		end else begin
			if (accept) begin
				out_valid <= 1'b1;
				flag_q    <= flag_d;  // Flags only move on acceptance
			end else if (out_ready) begin
				out_valid <= 1'b0;    // Response taken, nothing new
			end
		end
	end

	// Output payload, held under back-pressure
	always_ff @(posedge clk) begin
		if (accept) begin
			out_rsp.result <= alu_result;
			out_rsp.flags  <= flag_d;
		end
	end

endmodule

// File: source/logic_shift_unit.sv
module logic_shift_unit import cpu_pkg::*; (
	input  logic [DATA_W-1:0] a,
	input  logic [DATA_W-1:0] b,
	input  alu_op_e           op,
	output logic_out_t        logic_r
);

	logic              sra;     // 1 = arithmetic right, 0 = left
	logic              fill;    // Bit shifted in from the top
	logic [DATA_W-1:0] sh1, sh2, sh4, sh8;
	logic [DATA_W-1:0] ro1, ro2, ro4, ro8;

	assign sra  = op[0];
	assign fill = sra & a[DATA_W-1];

	// Barrel shifter, one stage per amount bit
	assign sh1 = ~b[0] ? a :
		(sra ? {fill, a[DATA_W-1:1]} : {a[DATA_W-2:0], 1'b0});
	assign sh2 = ~b[1] ? sh1 :
		(sra ? {{2{fill}}, sh1[DATA_W-1:2]} : {sh1[DATA_W-3:0], 2'b0});
	assign sh4 = ~b[2] ? sh2 :
		(sra ? {{4{fill}}, sh2[DATA_W-1:4]} : {sh2[DATA_W-5:0], 4'b0});
	assign sh8 = ~b[3] ? sh4 :
		(sra ? {{8{fill}}, sh4[DATA_W-1:8]} : {sh4[DATA_W-9:0], 8'b0});

	// Rotate right, same stage layout
	assign ro1 = b[0] ? {a[0], a[DATA_W-1:1]} : a;
	assign ro2 = b[1] ? {ro1[1:0], ro1[DATA_W-1:2]} : ro1;
	assign ro4 = b[2] ? {ro2[3:0], ro2[DATA_W-1:4]} : ro2;
	assign ro8 = b[3] ? {ro4[7:0], ro4[DATA_W-1:8]} : ro4;

	assign logic_r.xor_r = a ^ b;
	assign logic_r.shift = sh8;
	assign logic_r.ror   = ro8;

	// Byte loads keep the other half of a
	assign logic_r.llb = {a[DATA_W-1:8], b[7:0]};
	assign logic_r.lhb = {b[7:0], a[7:0]};

endmodule

// File: verification/exec_stage_tb.sv
module exec_stage_tb import cpu_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_RAND   = 200;  // Random mix of all 16 opcodes
	localparam int N_BP     = 80;   // Random mix under back-pressure
	localparam int N_STREAM = 16;   // Back-to-back burst
	localparam int N_REQ    = 10 + 48 + N_RAND + N_BP + N_STREAM;

	logic      clk = 1'b0;
	logic      rst_n;
	logic      in_valid;
	logic      in_ready;
	exec_req_t in_req;
	logic      out_valid;
	logic      out_ready;
	exec_rsp_t out_rsp;

	string      req_name;          // Travels with in_req
	bit         bp_on = 1'b0;      // Random out_ready when set
	int         cycle = 0;
	int         errors = 0;        // From the checker
	int         late_err = 0;      // From the stimulus process
	int         n_rsp = 0;
	exec_rsp_t  exp_q[$];          // Expected responses, oldest first
	string      name_q[$];
	exec_rsp_t  exp_rsp;
	string      exp_name;
	alu_flags_t model_flags;       // Model of the flag register
	bit         first_rsp = 1'b1;
	logic       in_reset, prev_acc, prev_hold;
	exec_rsp_t  prev_rsp;
	int         t0;

	exec_stage uut (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_req    (in_req),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_rsp   (out_rsp)
	);

	always #2 clk = ~clk;

	// Result of one instruction from the ISA rules
	function automatic logic [15:0] ref_result(exec_req_t r);
		int          hi, lo, x, y, s;
		logic [15:0] res;
		logic [3:0]  n;
		n = r.b[3:0];  // Shift amount
		res = '0;
		case (r.op)
			OP_ADD:    res = r.a + r.b;
			OP_SUB:    res = r.a - r.b;
			OP_XOR:    res = r.a ^ r.b;
			OP_SLL:    res = r.a << n;
			OP_SRA:    res = $signed(r.a) >>> n;
			OP_ROR:    res = (r.a >> n) | (r.a << (16 - n));  // n = 0 leaves a
			OP_RED: begin
				hi = 32'($signed(r.a[15:8])) + 32'($signed(r.b[15:8]));
				lo = 32'($signed(r.a[7:0])) + 32'($signed(r.b[7:0]));
				res = 16'(hi + lo);
			end
			OP_PADDSB: begin
				for (int k = 0; k < 4; k++) begin
					x = 32'($signed(r.a[4*k +: 4]));
					y = 32'($signed(r.b[4*k +: 4]));
					s = x + y;
					if (s > 7)
						s = 7;
					else if (s < -8)
						s = -8;
					res[4*k +: 4] = 4'(s);
				end
			end
			OP_LW, OP_SW: res = {r.a[15:1], 1'b0} + r.b;  // Aligned base
			OP_LLB:    res = {r.a[15:8], r.b[7:0]};
			OP_LHB:    res = {r.b[7:0], r.a[7:0]};
			default:   res = '0;
		endcase
		return res;
	endfunction

	// Flag register after one instruction
	function automatic alu_flags_t ref_flags(exec_req_t r, alu_flags_t f);
		logic [15:0] res;
		alu_flags_t  nf;
		res = ref_result(r);
		nf = f;
		if (r.op == OP_ADD || r.op == OP_SUB) begin
			nf.n = res[15];
			if (r.op == OP_ADD)
				nf.v = (r.a[15] == r.b[15]) && (res[15] != r.a[15]);
			else
				nf.v = (r.a[15] != r.b[15]) && (res[15] != r.a[15]);
		end
		if (r.op inside {OP_ADD, OP_SUB, OP_XOR, OP_SLL, OP_SRA, OP_ROR})
			nf.z = (res == 16'h0000);
		return nf;
	endfunction

	// One clock with out_ready refreshed on the edge
	task automatic tick();
		@(posedge clk);
		if (bp_on)
			out_ready <= ($urandom_range(0, 3) != 0);
		else
			out_ready <= 1'b1;
	endtask

	task automatic send(string name, logic [3:0] op, logic [15:0] a, logic [15:0] b);
		in_valid <= 1'b1;
		in_req   <= {op, a, b};
		req_name <= name;
		tick();
		while (!in_ready)
			tick();  // Held until accepted
		in_valid <= 1'b0;
	endtask

	// Checker sampling values before the edge updates them
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (!rst_n) begin
			in_reset  <= 1'b1;
			prev_acc  <= 1'b0;
			prev_hold <= 1'b0;
			model_flags = '0;
		end else begin
			if (in_reset)
				assert (out_valid === 1'b0) else begin
					errors++;
					$display("** Error [reset] expected out_valid 0, actual %b", out_valid);
				end
			if (prev_acc)
				assert (out_valid === 1'b1) else begin
					errors++;
					$display("** Error [latency] expected out_valid 1, actual %b", out_valid);
				end
			if (prev_hold)
				assert (out_valid === 1'b1 && out_rsp === prev_rsp) else begin
					errors++;
					$display("** Error [stall] expected %h valid 1, actual %h valid %b",
						prev_rsp, out_rsp, out_valid);
				end
			// Output slot is full while a modeled response is still pending
			assert (in_ready === (exp_q.size() == 0 || out_ready)) else begin
				errors++;
				$display("** Error [handshake] expected in_ready %b, actual %b",
					exp_q.size() == 0 || out_ready, in_ready);
			end
			if (out_valid && out_ready) begin  // Response leaves
				if (exp_q.size() == 0) begin
					errors++;
					$display("Error: response without a matching request");
				end else begin
					exp_rsp  = exp_q.pop_front();
					exp_name = name_q.pop_front();
					n_rsp++;
					assert (out_rsp === exp_rsp) else begin
						errors++;
						$display("** Error [%s] expected %h flags %b, actual %h flags %b",
							exp_name, exp_rsp.result, exp_rsp.flags, out_rsp.result, out_rsp.flags);
					end
					if (first_rsp)
						assert (out_rsp.flags === 3'b000) else begin
							errors++;
							$display("** Error [reset] expected flags 000, actual flags %b",
								out_rsp.flags);
						end
					first_rsp = 1'b0;
				end
			end
			if (in_valid && in_ready) begin  // Request accepted
				model_flags = ref_flags(in_req, model_flags);
				exp_rsp.result = ref_result(in_req);
				exp_rsp.flags  = model_flags;
				exp_q.push_back(exp_rsp);
				name_q.push_back(req_name);
			end
			in_reset  <= 1'b0;
			prev_acc  <= in_valid && in_ready;
			prev_hold <= out_valid && !out_ready;
			prev_rsp  <= out_rsp;
		end
	end

	initial begin
		#(4 * (N_REQ + 200));
		$display("Timeout: run did not finish within %0d cycles", N_REQ + 200);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		void'($urandom(32'h5ed8_9126));
		rst_n     <= 1'b0;
		in_valid  <= 1'b0;
		in_req    <= '0;
		req_name  <= "idle";
		out_ready <= 1'b1;
		repeat (2) tick();
		rst_n <= 1'b1;
		tick();

		// Flag sequence starting with an op that writes no flag
		send("reset_llb", OP_LLB, 16'h1234, 16'h0056);
		send("add_ovfl", OP_ADD, 16'h7fff, 16'h0001);      // Sets N and V
		send("xor_zero", OP_XOR, 16'h5a5a, 16'h5a5a);      // Z only
		send("paddsb_hold", OP_PADDSB, 16'h7788, 16'h1188); // Saturates high and low
		send("lw_hold", OP_LW, 16'h1001, 16'h0010);
		send("sub_wrap", OP_SUB, 16'h8000, 16'h0001);
		for (int op = 12; op < 16; op++)
			send("undefined", 4'(op), 16'($urandom), 16'($urandom));

		for (int amt = 0; amt < 16; amt++) begin  // Every shift amount
			send("sll", OP_SLL, 16'h9c35, 16'(amt));
			send("sra", OP_SRA, 16'h9c35, 16'(amt));
			send("ror", OP_ROR, 16'h9c35, 16'(amt));
		end

		repeat (N_RAND)
			send("random", 4'($urandom_range(0, 15)), 16'($urandom), 16'($urandom));

		bp_on = 1'b1;
		repeat (N_BP)
			send("backpressure", 4'($urandom_range(0, 15)), 16'($urandom), 16'($urandom));

		// Full rate burst with out_ready held high
		bp_on = 1'b0;
		repeat (2) tick();
		t0 = cycle;
		repeat (N_STREAM)
			send("stream", 4'($urandom_range(0, 11)), 16'($urandom), 16'($urandom));
		assert (cycle - t0 == N_STREAM) else begin
			late_err++;
			$display("** Error [stream] expected %0d cycles, actual %0d", N_STREAM, cycle - t0);
		end

		tick();
		while (out_valid)
			tick();
		tick();
		if (exp_q.size() != 0) begin
			late_err++;
			$display("Error: %0d accepted requests got no response", exp_q.size());
		end

		$display("Responses checked: %0d, errors: %0d", n_rsp, errors + late_err);
		if (errors + late_err == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule
